// ==== compile.f ====
+incdir+verilog
+incdir+verification
verilog/core_pkg.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/core_ctrl.sv
verilog/alu.sv
verilog/pipeline.sv
verilog/core.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module core_tb -f compile.f \
    -Mdir obj_dir -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log
then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== verification/core_tb_programs.svh ====
`ifndef CORE_TB_PROGRAMS_SVH
`define CORE_TB_PROGRAMS_SVH

////////////////////////////////////////
// Test table
////////////////////////////////////////

localparam int num_tests   = 6;
localparam int prog_len    = 8;
localparam int max_preset  = 4;
localparam int max_commits = 6;

// Load address, restart offset (-1 for none) and expected exception per row
string                    name_tbl    [num_tests];
logic [`CORE_IMEM_AW-1:0] base_tbl    [num_tests];
int                       restart_tbl [num_tests];
logic                     exc_tbl     [num_tests];
logic [`CORE_INSTR_W-1:0] prog_tbl    [num_tests][prog_len];
// Preset registers that NET_REG loads before the start
int                       pre_n       [num_tests];
logic [`CORE_RF_AW-1:0]   pre_addr    [num_tests][max_preset];
logic [`CORE_DATA_W-1:0]  pre_data    [num_tests][max_preset];
// Commit trace in program order
int                       exp_n       [num_tests];
logic [`CORE_RF_AW-1:0]   exp_addr    [num_tests][max_commits];
logic [`CORE_DATA_W-1:0]  exp_data    [num_tests][max_commits];

// Opcode, rd, then rs or a signed 5 bit offset
function automatic logic [`CORE_INSTR_W-1:0] encode_instr(input opcode_e op, input int rd,
                                                          input int rs_imm);
    instr_s ins;
    begin
        ins.opcode = op;
        ins.rd     = rd[`CORE_RF_AW-1:0];
        ins.rs_imm = rs_imm[`CORE_RF_AW-1:0];
        encode_instr = ins;
    end
endfunction

task automatic build_table();
    begin
        // ALU ops with r0 as a source and as a target
        name_tbl[0] = "alu_ops";
        base_tbl[0] = 10'h000;
        restart_tbl[0] = -1;
        exc_tbl[0] = 1'b0;
        prog_tbl[0] = '{encode_instr(OP_ADDU, 1, 2), encode_instr(OP_AND, 3, 4),
                        encode_instr(OP_OR, 4, 2), encode_instr(OP_SUBU, 2, 0),
                        encode_instr(OP_MOV, 0, 1), encode_instr(OP_MOV, 6, 0),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_DONE, 0, 0)};
        pre_n[0] = 4;
        pre_addr[0] = '{5'd1, 5'd2, 5'd3, 5'd4};
        pre_data[0] = '{32'd100, 32'h70, 32'hF0F0_00FF, 32'h0FF0_FF0F};
        exp_n[0] = 5;
        exp_addr[0] = '{5'd1, 5'd3, 5'd4, 5'd2, 5'd6, 5'd0};
        exp_data[0] = '{32'hD4, 32'h00F0_000F, 32'h0FF0_FF7F, 32'h70, 32'h0, 32'h0};
        // Dependent chain that forwards at distance 1 and reads through at distance 2
        name_tbl[1] = "forwarding";
        base_tbl[1] = 10'h010;
        restart_tbl[1] = -1;
        exc_tbl[1] = 1'b0;
        prog_tbl[1] = '{encode_instr(OP_ADDU, 1, 2), encode_instr(OP_ADDU, 1, 1),
                        encode_instr(OP_SUBU, 2, 1), encode_instr(OP_MOV, 3, 1),
                        encode_instr(OP_ADDU, 3, 2), encode_instr(OP_SUBU, 1, 3),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_DONE, 0, 0)};
        pre_n[1] = 2;
        pre_addr[1] = '{5'd1, 5'd2, 5'd0, 5'd0};
        pre_data[1] = '{32'd5, 32'd3, 32'd0, 32'd0};
        exp_n[1] = 6;
        exp_addr[1] = '{5'd1, 5'd1, 5'd2, 5'd3, 5'd3, 5'd1};
        exp_data[1] = '{32'd8, 32'd16, 32'hFFFF_FFF3, 32'd16, 32'd3, 32'd13};
        // Taken and untaken branches around a countdown loop with a backward offset
        name_tbl[2] = "branches";
        base_tbl[2] = 10'h040;
        restart_tbl[2] = -1;
        exc_tbl[2] = 1'b0;
        prog_tbl[2] = '{encode_instr(OP_BEQZ, 1, 2), encode_instr(OP_MOV, 4, 2),
                        encode_instr(OP_SUBU, 2, 3), encode_instr(OP_BNEQZ, 2, -1),
                        encode_instr(OP_BEQZ, 3, 3), encode_instr(OP_BNEQZ, 1, 2),
                        encode_instr(OP_MOV, 5, 3), encode_instr(OP_DONE, 0, 0)};
        pre_n[2] = 3;
        pre_addr[2] = '{5'd1, 5'd2, 5'd3, 5'd0};
        pre_data[2] = '{32'd0, 32'd3, 32'd1, 32'd0};
        exp_n[2] = 4;
        exp_addr[2] = '{5'd2, 5'd2, 5'd2, 5'd5, 5'd0, 5'd0};
        exp_data[2] = '{32'd2, 32'd1, 32'd0, 32'd1, 32'd0, 32'd0};
        // Call through r1 and return through the link in r4
        name_tbl[3] = "jalr";
        base_tbl[3] = 10'h100;
        restart_tbl[3] = -1;
        exc_tbl[3] = 1'b0;
        prog_tbl[3] = '{encode_instr(OP_JALR, 4, 1), encode_instr(OP_ADDU, 2, 2),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_MOV, 6, 2),
                        encode_instr(OP_MOV, 5, 2), encode_instr(OP_JALR, 0, 4),
                        encode_instr(OP_MOV, 6, 2), encode_instr(OP_DONE, 0, 0)};
        pre_n[3] = 2;
        pre_addr[3] = '{5'd1, 5'd2, 5'd0, 5'd0};
        pre_data[3] = '{32'h104, 32'h20, 32'd0, 32'd0};
        exp_n[3] = 3;
        exp_addr[3] = '{5'd4, 5'd5, 5'd2, 5'd0, 5'd0, 5'd0};
        exp_data[3] = '{32'h101, 32'h20, 32'h40, 32'd0, 32'd0, 32'd0};
        // DONE stops the core and a second start begins at offset 4
        name_tbl[4] = "done_restart";
        base_tbl[4] = 10'h200;
        restart_tbl[4] = 4;
        exc_tbl[4] = 1'b0;
        prog_tbl[4] = '{encode_instr(OP_ADDU, 1, 2), encode_instr(OP_DONE, 0, 0),
                        encode_instr(OP_OR, 2, 1), encode_instr(OP_MOV, 3, 1),
                        encode_instr(OP_SUBU, 2, 1), encode_instr(OP_MOV, 3, 2),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_ADDU, 1, 1)};
        pre_n[4] = 2;
        pre_addr[4] = '{5'd1, 5'd2, 5'd0, 5'd0};
        pre_data[4] = '{32'd1, 32'd2, 32'd0, 32'd0};
        exp_n[4] = 3;
        exp_addr[4] = '{5'd1, 5'd2, 5'd3, 5'd0, 5'd0, 5'd0};
        exp_data[4] = '{32'd3, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd0, 32'd0, 32'd0};
        // Endless loop on BEQZ r0 that only a PC packet in RUN can end
        name_tbl[5] = "pc_in_run";
        base_tbl[5] = 10'h3F8;
        restart_tbl[5] = -1;
        exc_tbl[5] = 1'b1;
        prog_tbl[5] = '{encode_instr(OP_ADDU, 1, 2), encode_instr(OP_MOV, 3, 1),
                        encode_instr(OP_BEQZ, 0, 0), encode_instr(OP_DONE, 0, 0),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_DONE, 0, 0),
                        encode_instr(OP_DONE, 0, 0), encode_instr(OP_DONE, 0, 0)};
        // Nonzero write to r0 must still leave it reading zero
        pre_n[5] = 3;
        pre_addr[5] = '{5'd1, 5'd2, 5'd0, 5'd0};
        pre_data[5] = '{32'h11, 32'h22, 32'h5A5A_5A5A, 32'd0};
        exp_n[5] = 2;
        exp_addr[5] = '{5'd1, 5'd3, 5'd0, 5'd0, 5'd0, 5'd0};
        exp_data[5] = '{32'h33, 32'h33, 32'd0, 32'd0, 32'd0, 32'd0};
    end
endtask

`endif

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb;
    import core_pkg::*;

    `include "core_tb_programs.svh"

    // This core answers to own_id only
    localparam logic [`CORE_NET_ID_W-1:0] own_id   = 10'h2A5;
    localparam logic [`CORE_NET_ID_W-1:0] other_id = 10'h2A4;

    logic                     clk;
    logic                     n_reset;
    logic [`CORE_NET_ID_W-1:0] net_id;
    net_op_e                  net_op;
    logic [`CORE_IMEM_AW-1:0] net_addr;
    logic [`CORE_DATA_W-1:0]  net_data;
    logic                     commit_valid;
    logic [`CORE_RF_AW-1:0]   commit_addr;
    logic [`CORE_DATA_W-1:0]  commit_data;
    logic                     idle;
    logic                     exception;
    int                       errors;
    int                       tests_failed;
    int                       cycles;
    int                       cycle_limit;

    core #(
        .net_id_p (own_id)
    ) core_i (
        .clk (clk), .n_reset (n_reset),
        .net_id_i (net_id), .net_op_i (net_op), .net_addr_i (net_addr), .net_data_i (net_data),
        .commit_valid_o (commit_valid), .commit_addr_o (commit_addr),
        .commit_data_o (commit_data), .idle_o (idle), .exception_o (exception)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the core never went back to idle", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        begin
            if (got !== exp)
            begin
                $display("FAIL %0t %s got %h expected %h", $time, sig, got, exp);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Bus driving
    ////////////////////////////////////////

    // Inputs change 5 ns after the rising edge
    task automatic apply_reset();
        begin
            @(posedge clk);
            #5;
            n_reset = 1'b0;
            net_op  = NET_NONE;
            repeat (4) @(posedge clk);
            #5;
            n_reset = 1'b1;
        end
    endtask

    // Packet is taken at the next rising edge
    task automatic send_packet(input logic [`CORE_NET_ID_W-1:0] id, input net_op_e op,
                               input logic [`CORE_IMEM_AW-1:0] addr,
                               input logic [`CORE_DATA_W-1:0] data);
        begin
            @(posedge clk);
            #5;
            net_id   = id;
            net_op   = op;
            net_addr = addr;
            net_data = data;
        end
    endtask

    task automatic log_commit(input int t, inout int seen);
        begin
            if (seen < exp_n[t])
            begin
                check_value("commit_addr_o", commit_addr, exp_addr[t][seen]);
                check_value("commit_data_o", commit_data, exp_data[t][seen]);
            end
            else
            begin
                $display("Test %0d made an extra commit to r%0d at %0t", t, commit_addr, $time);
                errors++;
            end
            seen++;
        end
    endtask

    // Sampled at the falling edge, where outputs are settled
    task automatic collect_commits(input int t, inout int seen);
        bit stop;
        bit own_sent;
        int inj_step;
        begin
            stop = 1'b0;
            inj_step = 0;
            while (!stop)
            begin
                @(posedge clk);
                #5;
                net_op   = NET_NONE;
                own_sent = 1'b0;
                // Foreign PC first, then one for this core
                if (exc_tbl[t] && (seen >= exp_n[t]) && (inj_step < 2))
                begin
                    net_id   = (inj_step == 0) ? other_id : own_id;
                    net_op   = NET_PC;
                    net_addr = base_tbl[t];
                    own_sent = (inj_step == 1);
                    inj_step++;
                end
                @(negedge clk);
                if (commit_valid)
                    log_commit(t, seen);
                // Foreign PC has been taken by now and must leave no trace
                if (own_sent)
                    check_value("exception_o", exception, 32'd0);
                if (idle || exception)
                    stop = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int t);
        int err_before;
        int seen;
        begin
            err_before = errors;
            seen = 0;
            apply_reset();
            for (int i = 0; i < prog_len; i++)
                send_packet(own_id, NET_INSTR, base_tbl[t] + i[`CORE_IMEM_AW-1:0],
                            {16'h0000, prog_tbl[t][i]});
            for (int i = 0; i < pre_n[t]; i++)
                send_packet(own_id, NET_REG, {5'd0, pre_addr[t][i]}, pre_data[t][i]);
            // Junk for the first preset register, with another ID
            send_packet(other_id, NET_REG, {5'd0, pre_addr[t][0]}, 32'hDEAD_BEEF);
            send_packet(own_id, NET_PC, base_tbl[t], '0);
            collect_commits(t, seen);
            if (restart_tbl[t] >= 0)
            begin
                send_packet(own_id, NET_PC,
                            base_tbl[t] + restart_tbl[t][`CORE_IMEM_AW-1:0], '0);
                collect_commits(t, seen);
            end
            // ERR holds until reset
            if (exc_tbl[t])
            begin
                repeat (3) @(negedge clk);
                check_value("idle_o", idle, 32'd0);
            end
            check_value("exception_o", exception, exc_tbl[t]);
            if (seen < exp_n[t])
            begin
                $display("Test %0d saw %0d of %0d commits", t, seen, exp_n[t]);
                errors++;
            end
            if (errors != err_before)
                tests_failed++;
            $display("Test %0d %s %s", t, name_tbl[t], (errors == err_before) ? "ok" : "failed");
        end
    endtask

    initial
    begin
        clk = 1'b0;
        n_reset = 1'b0;
        net_id = '0;
        net_op = NET_NONE;
        net_addr = '0;
        net_data = '0;
        errors = 0;
        tests_failed = 0;
        cycles = 0;
        build_table();
        // Packets of every row plus 40 cycles each, doubled
        cycle_limit = 0;
        for (int t = 0; t < num_tests; t++)
            cycle_limit += prog_len + pre_n[t] + 2 + ((restart_tbl[t] >= 0) ? 1 : 0)
                         + (exc_tbl[t] ? 2 : 0) + 40;
        cycle_limit *= 2;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, num_tests - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/core.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core #(
    parameter logic [`CORE_NET_ID_W-1:0] net_id_p = 1
) (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic [`CORE_NET_ID_W-1:0] net_id_i,
    input  core_pkg::net_op_e         net_op_i,
    input  logic [`CORE_IMEM_AW-1:0]  net_addr_i,
    input  logic [`CORE_DATA_W-1:0]   net_data_i,
    output logic                      commit_valid_o,
    output logic [`CORE_RF_AW-1:0]    commit_addr_o,
    output logic [`CORE_DATA_W-1:0]   commit_data_o,
    output logic                      idle_o,
    output logic                      exception_o
);
    import core_pkg::*;

    // Control to pipeline
    logic                     imem_wen, rf_net_wen, start, run, halt_clear;
    logic [`CORE_IMEM_AW-1:0] imem_waddr, start_pc;
    instr_s                   imem_wdata;
    logic [`CORE_RF_AW-1:0]   rf_net_addr;
    net_data_u                rf_net_data;
    // Pipeline to control
    logic                     done_seen;

    core_ctrl #(
        .net_id_p (net_id_p)
    ) ctrl_i (
        .clk (clk), .n_reset (n_reset),
        .net_id_i (net_id_i), .net_op_i (net_op_i),
        .net_addr_i (net_addr_i), .net_data_i (net_data_i),
        .done_seen_i (done_seen),
        .imem_wen_o (imem_wen), .imem_waddr_o (imem_waddr), .imem_wdata_o (imem_wdata),
        .rf_net_wen_o (rf_net_wen), .rf_net_addr_o (rf_net_addr),
        .rf_net_data_o (rf_net_data),
        .start_o (start), .start_pc_o (start_pc), .run_o (run), .flush_o (halt_clear),
        .idle_o (idle_o), .exception_o (exception_o)
    );

    pipeline pipe_i (
        .clk (clk), .n_reset (n_reset),
        .imem_wen_i (imem_wen), .imem_waddr_i (imem_waddr), .imem_wdata_i (imem_wdata),
        .rf_net_wen_i (rf_net_wen), .rf_net_addr_i (rf_net_addr),
        .rf_net_data_i (rf_net_data),
        .start_i (start), .start_pc_i (start_pc), .run_i (run), .flush_i (halt_clear),
        .done_seen_o (done_seen),
        .commit_valid_o (commit_valid_o), .commit_addr_o (commit_addr_o),
        .commit_data_o (commit_data_o)
    );

endmodule

// ==== verilog/pipeline.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module pipeline (
    input  logic                     clk,
    input  logic                     n_reset,
    input  logic                     imem_wen_i,
    input  logic [`CORE_IMEM_AW-1:0] imem_waddr_i,
    input  core_pkg::instr_s         imem_wdata_i,
    input  logic                     rf_net_wen_i,
    input  logic [`CORE_RF_AW-1:0]   rf_net_addr_i,
    input  core_pkg::net_data_u      rf_net_data_i,
    input  logic                     start_i,
    input  logic [`CORE_IMEM_AW-1:0] start_pc_i,
    input  logic                     run_i,
    input  logic                     flush_i,
    output logic                     done_seen_o,
    output logic                     commit_valid_o,
    output logic [`CORE_RF_AW-1:0]   commit_addr_o,
    output logic [`CORE_DATA_W-1:0]  commit_data_o
);
    import core_pkg::*;

    // Fetch
    logic [`CORE_IMEM_AW-1:0] pc_r, pc_next, imem_addr;
    logic                     f_valid_r;
    instr_s                   f_instr;
    // Decode
    logic                     d_valid_r;
    instr_s                   d_instr_r;
    logic [`CORE_IMEM_AW-1:0] d_pc_r;
    logic [`CORE_DATA_W-1:0]  d_rs_val, d_rd_val;
    // Execute
    logic                     x_valid_r, x_writes_rf, alu_jump, redirect, kill;
    instr_s                   x_instr_r;
    logic [`CORE_IMEM_AW-1:0] x_pc_r, x_target;
    logic [`CORE_DATA_W-1:0]  x_rs_r, x_rd_r, x_rs_val, x_rd_val, alu_result;
    // Writeback
    logic                     w_valid_r, w_writes_r, w_commit;
    instr_s                   w_instr_r;
    logic [`CORE_IMEM_AW-1:0] w_pc_r;
    logic [`CORE_DATA_W-1:0]  w_result_r, w_data;
    // Register file write port
    logic                     rf_wen;
    logic [`CORE_RF_AW-1:0]   rf_waddr;
    logic [`CORE_DATA_W-1:0]  rf_wdata;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    // Memory is addressed with next PC, so f_instr lines up with pc_r
    assign pc_next   = start_i  ? start_pc_i
                     : redirect ? x_target
                     : pc_r + 1'b1;
    assign imem_addr = imem_wen_i ? imem_waddr_i : pc_next;

    instr_mem imem_i (
        .clk     (clk),
        .addr_i  (imem_addr),
        .wen_i   (imem_wen_i),
        .wdata_i (imem_wdata_i),
        .instr_o (f_instr)
    );

    // Decode reads, execute takes the forwarded writeback value
    reg_file rf_i (
        .clk       (clk),
        .rs_addr_i (d_instr_r.rs_imm),
        .rd_addr_i (d_instr_r.rd),
        .w_addr_i  (rf_waddr),
        .wen_i     (rf_wen),
        .w_data_i  (rf_wdata),
        .rs_val_o  (d_rs_val),
        .rd_val_o  (d_rd_val)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    // Forward from writeback, w_commit already excludes r0
    assign x_rs_val = (w_commit && (w_instr_r.rd == x_instr_r.rs_imm)) ? w_data : x_rs_r;
    assign x_rd_val = (w_commit && (w_instr_r.rd == x_instr_r.rd)) ? w_data : x_rd_r;

    alu alu_i (
        .instr_i  (x_instr_r),
        .rs_i     (x_rs_val),
        .rd_i     (x_rd_val),
        .result_o (alu_result),
        .jump_o   (alu_jump)
    );

    // Branch offset is relative to the branch itself
    assign x_target = (x_instr_r.opcode == OP_JALR) ? alu_result[`CORE_IMEM_AW-1:0]
        : x_pc_r + {{(`CORE_IMEM_AW-`CORE_RF_AW){x_instr_r.rs_imm[`CORE_RF_AW-1]}},
                    x_instr_r.rs_imm};

    assign redirect    = x_valid_r && alu_jump;
    assign done_seen_o = x_valid_r && (x_instr_r.opcode == OP_DONE);
    // Younger fetch and decode slots die
    assign kill        = redirect || done_seen_o || flush_i;

    always_comb
    begin
        case (x_instr_r.opcode)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_MOV, OP_JALR:
                x_writes_rf = 1'b1;
            default:
                x_writes_rf = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    // JALR links PC+1
    assign w_data   = (w_instr_r.opcode == OP_JALR)
                    ? {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, w_pc_r + 1'b1} : w_result_r;
    assign w_commit = w_valid_r && w_writes_r && (w_instr_r.rd != '0);

    // Network writes only come in IDLE
    assign rf_wen   = rf_net_wen_i || w_commit;
    assign rf_waddr = rf_net_wen_i ? rf_net_addr_i : w_instr_r.rd;
    assign rf_wdata = rf_net_wen_i ? rf_net_data_i.word : w_data;

    assign commit_valid_o = w_commit;
    assign commit_addr_o  = w_instr_r.rd;
    assign commit_data_o  = w_data;

    // PC and stage valid bits
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            pc_r      <= '0;
            f_valid_r <= 1'b0;
            d_valid_r <= 1'b0;
            x_valid_r <= 1'b0;
            w_valid_r <= 1'b0;
        end
        else
        begin
            pc_r      <= pc_next;
            // Fetch stops after DONE or on flush
            f_valid_r <= start_i || (f_valid_r && run_i && !done_seen_o && !flush_i);
            d_valid_r <= f_valid_r && !kill;
            x_valid_r <= d_valid_r && !kill;
            w_valid_r <= x_valid_r && !flush_i;
        end
    end

    // Stage payload
    always_ff @(posedge clk)
    begin
        d_instr_r  <= f_instr;
        d_pc_r     <= pc_r;
        x_instr_r  <= d_instr_r;
        x_pc_r     <= d_pc_r;
        x_rs_r     <= d_rs_val;
        x_rd_r     <= d_rd_val;
        w_instr_r  <= x_instr_r;
        w_pc_r     <= x_pc_r;
        w_result_r <= alu_result;
        w_writes_r <= x_writes_rf;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module alu (
    input  core_pkg::instr_s        instr_i,
    input  logic [`CORE_DATA_W-1:0] rs_i,
    input  logic [`CORE_DATA_W-1:0] rd_i,
    output logic [`CORE_DATA_W-1:0] result_o,
    output logic                    jump_o
);
    import core_pkg::*;

    // Result is rd op rs
    // Branches only look at rd and produce no result
    always_comb
    begin
        result_o = '0;
        jump_o   = 1'b0;
        case (instr_i.opcode)
            OP_ADDU:
                result_o = rd_i + rs_i;
            OP_SUBU:
                result_o = rd_i - rs_i;
            OP_AND:
                result_o = rd_i & rs_i;
            OP_OR:
                result_o = rd_i | rs_i;
            OP_MOV:
                result_o = rs_i;
            // Jump target comes out on the result
            OP_JALR:
            begin
                result_o = rs_i;
                jump_o   = 1'b1;
            end
            // Taken when rd is zero
            OP_BEQZ:
                jump_o = (rd_i == '0);
            // Taken when rd is nonzero
            OP_BNEQZ:
                jump_o = (rd_i != '0);
            // DONE and unknown codes do nothing here
            default:
            begin
                result_o = '0;
                jump_o   = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/core_ctrl.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_ctrl #(
    parameter logic [`CORE_NET_ID_W-1:0] net_id_p = 1
) (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic [`CORE_NET_ID_W-1:0] net_id_i,
    input  core_pkg::net_op_e         net_op_i,
    input  logic [`CORE_IMEM_AW-1:0]  net_addr_i,
    input  logic [`CORE_DATA_W-1:0]   net_data_i,
    input  logic                      done_seen_i,
    output logic                      imem_wen_o,
    output logic [`CORE_IMEM_AW-1:0]  imem_waddr_o,
    output core_pkg::instr_s          imem_wdata_o,
    output logic                      rf_net_wen_o,
    output logic [`CORE_RF_AW-1:0]    rf_net_addr_o,
    output core_pkg::net_data_u       rf_net_data_o,
    output logic                      start_o,
    output logic [`CORE_IMEM_AW-1:0]  start_pc_o,
    output logic                      run_o,
    output logic                      flush_o,
    output logic                      idle_o,
    output logic                      exception_o
);
    import core_pkg::*;

    core_state_e state_r;
    core_state_e state_n;
    net_data_u   pkt_data;
    logic        pkt_hit;
    logic        pc_cmd;
    logic        instr_cmd;
    logic        reg_cmd;
    logic        bad_pkt;

    ////////////////////////////////////////
    // Packet decode
    ////////////////////////////////////////

    // Only packets addressed to this core count
    assign pkt_hit   = (net_id_i == net_id_p) && (net_op_i != NET_NONE);
    assign pc_cmd    = pkt_hit && (net_op_i == NET_PC);
    assign instr_cmd = pkt_hit && (net_op_i == NET_INSTR);
    assign reg_cmd   = pkt_hit && (net_op_i == NET_REG);
    assign pkt_data  = net_data_i;

    // PC outside IDLE, or a load while running
    assign bad_pkt = (pc_cmd && (state_r != IDLE))
                  || ((instr_cmd || reg_cmd) && (state_r == RUN));

    // Commands only act in IDLE
    assign imem_wen_o    = instr_cmd && (state_r == IDLE);
    assign imem_waddr_o  = net_addr_i;
    assign imem_wdata_o  = pkt_data.view.instr;
    assign rf_net_wen_o  = reg_cmd && (state_r == IDLE);
    assign rf_net_addr_o = net_addr_i[`CORE_RF_AW-1:0];
    assign rf_net_data_o = pkt_data;
    assign start_o       = pc_cmd && (state_r == IDLE);
    assign start_pc_o    = net_addr_i;

    ////////////////////////////////////////
    // Run state machine
    ////////////////////////////////////////

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            IDLE:
                if (start_o)
                    state_n = RUN;
            // Bad packet wins over a DONE in the same cycle
            RUN:
                if (bad_pkt)
                    state_n = ERR;
                else if (done_seen_i)
                    state_n = IDLE;
            // ERR is left only through reset
            default:
                state_n = ERR;
        endcase
    end

    // Clear the pipeline as ERR is entered
    assign flush_o = (state_n == ERR) && (state_r != ERR);
    assign run_o   = (state_r == RUN);
    assign idle_o  = (state_r == IDLE);

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            state_r     <= state_n;
            // Sticky until reset
            exception_o <= exception_o || bad_pkt;
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic                    clk,
    input  logic [`CORE_RF_AW-1:0]  rs_addr_i,
    input  logic [`CORE_RF_AW-1:0]  rd_addr_i,
    input  logic [`CORE_RF_AW-1:0]  w_addr_i,
    input  logic                    wen_i,
    input  logic [`CORE_DATA_W-1:0] w_data_i,
    output logic [`CORE_DATA_W-1:0] rs_val_o,
    output logic [`CORE_DATA_W-1:0] rd_val_o
);

    // 32 general registers
    logic [`CORE_DATA_W-1:0] regs [2**`CORE_RF_AW];

    always_ff @(posedge clk)
    begin
        if (wen_i)
        begin
            regs[w_addr_i] <= w_data_i;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Register 0 is hardwired to zero
    // Same cycle write is passed straight through
    always_comb
    begin
        if (rs_addr_i == '0)
            rs_val_o = '0;
        else if (wen_i && (w_addr_i == rs_addr_i))
            rs_val_o = w_data_i;
        else
            rs_val_o = regs[rs_addr_i];
    end

    always_comb
    begin
        if (rd_addr_i == '0)
            rd_val_o = '0;
        else if (wen_i && (w_addr_i == rd_addr_i))
            rd_val_o = w_data_i;
        else
            rd_val_o = regs[rd_addr_i];
    end

endmodule

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_mem (
    input  logic                     clk,
    input  logic [`CORE_IMEM_AW-1:0] addr_i,
    input  logic                     wen_i,
    input  core_pkg::instr_s         wdata_i,
    output core_pkg::instr_s         instr_o
);
    import core_pkg::*;

    // Program storage
    instr_s mem [2**`CORE_IMEM_AW];

    // Single port shared by network writes and fetch
    // Read data shows up one cycle after the address
    always_ff @(posedge clk)
    begin
        if (wen_i)
        begin
            mem[addr_i] <= wdata_i;
        end
        instr_o <= mem[addr_i];
    end

endmodule

// ==== verilog/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    // Opcode field
    // Codes not listed here behave as no-ops
    typedef enum logic [5:0] {
        OP_ADDU  = 6'h01,
        OP_SUBU  = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_MOV   = 6'h05,
        OP_BEQZ  = 6'h08,
        OP_BNEQZ = 6'h09,
        OP_JALR  = 6'h0C,
        OP_DONE  = 6'h3F
    } opcode_e;

    // rs_imm is a register number, or a signed branch offset
    typedef struct packed {
        opcode_e                opcode;
        logic [`CORE_RF_AW-1:0] rd;
        logic [`CORE_RF_AW-1:0] rs_imm;
    } instr_s;

    // Network packet operation
    typedef enum logic [1:0] {
        NET_NONE  = 2'd0,
        NET_PC    = 2'd1,
        NET_INSTR = 2'd2,
        NET_REG   = 2'd3
    } net_op_e;

    // Run state of the core
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        ERR  = 2'd2
    } core_state_e;

    // Instruction carried in the low half of a packet word
    typedef struct packed {
        logic [`CORE_DATA_W-`CORE_INSTR_W-1:0] rsvd;
        instr_s                                instr;
    } net_instr_view_s;

    // Packet data field, either a register value or an instruction
    typedef union packed {
        logic [`CORE_DATA_W-1:0] word;
        net_instr_view_s         view;
    } net_data_u;

endpackage

// ==== verilog/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Register word and ALU width
`define CORE_DATA_W 32

// One instruction word
`define CORE_INSTR_W 16

////////////////////////////////////////
// Address spaces
////////////////////////////////////////

// Instruction memory, 1024 entries
`define CORE_IMEM_AW 10

// Register file, 32 entries
`define CORE_RF_AW 5

// Network packet ID
`define CORE_NET_ID_W 10

`endif
